// File: Makefile
# Verilator build and run of the command sequencer testbench

VERILATOR ?= verilator
TOP       ?= tb_cmd_seq
FLIST     ?= all.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
PASS_TEXT ?= all tests passed

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) -f $(FLIST) --top-module $(TOP) -Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee /dev/stderr | grep -q "$(PASS_TEXT)"

clean:
	rm -rf $(BUILD_DIR)

// File: all.f
+incdir+.
cmd_seq_pkg.sv
cmd_seq_regs.sv
cmd_seq_engine.sv
cmd_seq_serializer.sv
cmd_seq_top.sv
cmd_seq_chk.sv
tb_cmd_seq.sv

// File: cmd_seq_chk.sv
// assertions on the sequencer top level: AXI response hold, idle data and start-pulse rules
module cmd_seq_chk (
    input logic CMD_CLK_IN,
    input logic RST_CMD_CLK,
    input logic s_axi_bvalid,
    input logic s_axi_bready,
    input logic s_axi_rvalid,
    input logic s_axi_rready,
    input logic cmd_data,
    input logic cmd_ready,
    input logic cmd_start_flag
);
    timeunit 1ns;
    timeprecision 100ps;

    // responses wait for their ready
    bvalid_hold: assert property (@(posedge CMD_CLK_IN) disable iff (RST_CMD_CLK)
        s_axi_bvalid && !s_axi_bready |=> s_axi_bvalid)
        else $error("bvalid dropped before bready");

    rvalid_hold: assert property (@(posedge CMD_CLK_IN) disable iff (RST_CMD_CLK)
        s_axi_rvalid && !s_axi_rready |=> s_axi_rvalid)
        else $error("rvalid dropped before rready");

    // idle line stays low
    idle_data: assert property (@(posedge CMD_CLK_IN) disable iff (RST_CMD_CLK)
        cmd_ready |-> !cmd_data)
        else $error("cmd_data high while ready");

    idle_flag: assert property (@(posedge CMD_CLK_IN) disable iff (RST_CMD_CLK)
        $rose(cmd_start_flag) |-> !cmd_ready)
        else $error("start flag rose while ready");

endmodule

bind cmd_seq_top cmd_seq_chk u_chk (.*);

// File: cmd_seq_engine.sv
// sequencing FSM with config snapshot, bit counter, repeat counter and bit requests
`include "cmd_seq_settings.svh"

module cmd_seq_engine (
    input  logic                      CMD_CLK_IN,
    input  logic                      RST_CMD_CLK,
    input  cmd_seq_pkg::cmd_seq_cfg_t cfg,
    input  logic                      start,
    input  logic                      soft_rst,
    input  logic                      ext_start,
    input  logic                      ready,
    output cmd_seq_pkg::cmd_seq_bit_t bit_req,
    output logic                      ext_start_enable
);

    typedef enum logic {
        S_IDLE,
        S_RUN
    } state_t;

    state_t      state;
    logic [15:0] cnt;
    logic [31:0] rep_left;
    logic [15:0] start_rep;
    logic [15:0] body_last;
    logic [15:0] last_addr;
    logic        cfg_ok;
    logic        accept;
    logic        at_body_last;
    logic        at_end;

    assign ext_start_enable = cfg.en_ext_start;

    // header plus trailer has to leave at least one body bit
    assign cfg_ok = ({1'b0, cfg.start_rep} + {1'b0, cfg.stop_rep}) < {1'b0, cfg.size};

    // requests while busy are simply lost
    assign accept = (start || (ext_start && cfg.en_ext_start))
                    && ready && state == S_IDLE && cfg_ok;

    assign at_body_last = cnt == body_last;
    assign at_end       = cnt == last_addr && rep_left == 32'd1;

    always_ff @(posedge CMD_CLK_IN) begin
        if (RST_CMD_CLK || soft_rst) begin
            state <= S_IDLE;
        end else begin
            case (state)
                S_IDLE: begin
                    if (accept) begin
                        state <= S_RUN;
                    end
                end
                S_RUN: begin
                    if (at_end) begin
                        state <= S_IDLE;
                    end
                end
                default: state <= S_IDLE;
            endcase
        end
    end

    // while idle the snapshot tracks cfg, so the accepting edge freezes it
    always_ff @(posedge CMD_CLK_IN) begin
        if (state == S_IDLE) begin
            cnt       <= '0;
            start_rep <= cfg.start_rep;
            body_last <= cfg.size - cfg.stop_rep - 16'd1;
            last_addr <= cfg.size - 16'd1;
            rep_left  <= (cfg.repeat_cnt == '0) ? 32'd1 : cfg.repeat_cnt;
        end else if (at_body_last && rep_left != 32'd1) begin
            // back to the first body bit for another pass
            cnt      <= start_rep;
            rep_left <= rep_left - 32'd1;
        end else begin
            cnt <= cnt + 16'd1;
        end
    end

    // one request per running cycle
    always_ff @(posedge CMD_CLK_IN) begin
        bit_req.bit_addr   <= cnt[`CMD_SEQ_BIT_ADDR_W-1:0];
        bit_req.body_first <= cnt == start_rep;
        bit_req.last       <= at_end;
        if (RST_CMD_CLK || soft_rst) begin
            bit_req.valid <= 1'b0;
        end else begin
            bit_req.valid <= state == S_RUN;
        end
    end

endmodule

// File: cmd_seq_pkg.sv
// configuration struct and bit-request struct of the command sequencer
`include "cmd_seq_settings.svh"

package cmd_seq_pkg;

    // live configuration from the register file, 82 bits
    typedef struct packed {
        logic [15:0] size;
        // 0 is handled as a single pass
        logic [31:0] repeat_cnt;
        logic [15:0] start_rep;
        logic [15:0] stop_rep;
        logic        en_ext_start;
        logic        dis_cmd_pulse;
    } cmd_seq_cfg_t;

    // one pattern bit to send, 14 bits
    typedef struct packed {
        logic                           valid;
        logic [`CMD_SEQ_BIT_ADDR_W-1:0] bit_addr;
        // first body bit of a pass
        logic                           body_first;
        // final bit of the whole stream
        logic                           last;
    } cmd_seq_bit_t;

endpackage

// File: cmd_seq_regs.sv
// AXI4-Lite register file, command memory with byte read port, start and soft-reset pulses
`include "cmd_seq_settings.svh"

module cmd_seq_regs (
    input  logic                           CMD_CLK_IN,
    input  logic                           RST_CMD_CLK,
    input  logic [`CMD_SEQ_AXI_ADDR_W-1:0] s_axi_awaddr,
    input  logic                           s_axi_awvalid,
    output logic                           s_axi_awready,
    input  logic [31:0]                    s_axi_wdata,
    input  logic [3:0]                     s_axi_wstrb,
    input  logic                           s_axi_wvalid,
    output logic                           s_axi_wready,
    output logic [1:0]                     s_axi_bresp,
    output logic                           s_axi_bvalid,
    input  logic                           s_axi_bready,
    input  logic [`CMD_SEQ_AXI_ADDR_W-1:0] s_axi_araddr,
    input  logic                           s_axi_arvalid,
    output logic                           s_axi_arready,
    output logic [31:0]                    s_axi_rdata,
    output logic [1:0]                     s_axi_rresp,
    output logic                           s_axi_rvalid,
    input  logic                           s_axi_rready,
    output cmd_seq_pkg::cmd_seq_cfg_t      cfg,
    output logic                           start,
    output logic                           soft_rst,
    input  logic [`CMD_SEQ_MEM_ADDR_W-1:0] mem_rd_addr,
    output logic [7:0]                     mem_rd_data,
    input  logic                           ready
);

    localparam logic [`CMD_SEQ_AXI_ADDR_W-1:0] MEM_BASE = `CMD_SEQ_MEM_BASE;
    localparam int AW = `CMD_SEQ_AXI_ADDR_W;
    localparam int MW = `CMD_SEQ_MEM_ADDR_W;

    logic [7:0]  mem [`CMD_SEQ_MEM_BYTES];
    logic        wr_fire;
    logic        rd_fire;
    logic        wr_is_mem;
    logic        rd_is_mem;
    logic [31:0] rd_value;

    assign wr_fire   = s_axi_awvalid && s_axi_wvalid && s_axi_awready;
    assign rd_fire   = s_axi_arvalid && s_axi_arready;
    // memory window is aligned to its own size
    assign wr_is_mem = s_axi_awaddr[AW-1:MW] == MEM_BASE[AW-1:MW];
    assign rd_is_mem = s_axi_araddr[AW-1:MW] == MEM_BASE[AW-1:MW];

    assign start    = wr_fire && s_axi_awaddr == `CMD_SEQ_REG_START;
    assign soft_rst = wr_fire && s_axi_awaddr == `CMD_SEQ_REG_RESET;

    assign s_axi_wready = s_axi_awready;
    assign s_axi_bresp  = 2'b00;
    assign s_axi_rresp  = 2'b00;

    // write handshake, one request per response
    always_ff @(posedge CMD_CLK_IN) begin
        if (RST_CMD_CLK) begin
            s_axi_awready <= 1'b0;
            s_axi_bvalid  <= 1'b0;
        end else begin
            s_axi_awready <= s_axi_awvalid && s_axi_wvalid && !s_axi_bvalid && !s_axi_awready;
            if (wr_fire) begin
                s_axi_bvalid <= 1'b1;
            end else if (s_axi_bready) begin
                s_axi_bvalid <= 1'b0;
            end
        end
    end

    // read handshake
    always_ff @(posedge CMD_CLK_IN) begin
        if (RST_CMD_CLK) begin
            s_axi_arready <= 1'b0;
            s_axi_rvalid  <= 1'b0;
        end else begin
            s_axi_arready <= s_axi_arvalid && !s_axi_rvalid && !s_axi_arready;
            if (rd_fire) begin
                s_axi_rvalid <= 1'b1;
            end else if (s_axi_rready) begin
                s_axi_rvalid <= 1'b0;
            end
        end
    end

    always_ff @(posedge CMD_CLK_IN) begin
        if (rd_fire) begin
            s_axi_rdata <= rd_value;
        end
    end

    // configuration registers, byte strobes honoured
    always_ff @(posedge CMD_CLK_IN) begin
        if (RST_CMD_CLK || soft_rst) begin
            cfg.size          <= '0;
            cfg.repeat_cnt    <= `CMD_SEQ_REPEAT_DEFAULT;
            cfg.start_rep     <= '0;
            cfg.stop_rep      <= '0;
            cfg.en_ext_start  <= 1'b0;
            cfg.dis_cmd_pulse <= 1'b0;
        end else if (wr_fire) begin
            for (int i = 0; i < 4; i++) begin
                if (s_axi_wstrb[i]) begin
                    if (s_axi_awaddr == `CMD_SEQ_REG_REPEAT) begin
                        cfg.repeat_cnt[8*i +: 8] <= s_axi_wdata[8*i +: 8];
                    end
                    if (i < 2 && s_axi_awaddr == `CMD_SEQ_REG_SIZE) begin
                        cfg.size[8*i +: 8] <= s_axi_wdata[8*i +: 8];
                    end
                    if (i < 2 && s_axi_awaddr == `CMD_SEQ_REG_START_REP) begin
                        cfg.start_rep[8*i +: 8] <= s_axi_wdata[8*i +: 8];
                    end
                    if (i < 2 && s_axi_awaddr == `CMD_SEQ_REG_STOP_REP) begin
                        cfg.stop_rep[8*i +: 8] <= s_axi_wdata[8*i +: 8];
                    end
                end
            end
            if (s_axi_awaddr == `CMD_SEQ_REG_CONF && s_axi_wstrb[0]) begin
                cfg.en_ext_start  <= s_axi_wdata[0];
                cfg.dis_cmd_pulse <= s_axi_wdata[1];
            end
        end
    end

    // pattern byte k lives in word k/4, lane k%4
    always_ff @(posedge CMD_CLK_IN) begin
        if (wr_fire && wr_is_mem) begin
            for (int i = 0; i < 4; i++) begin
                if (s_axi_wstrb[i]) begin
                    mem[{s_axi_awaddr[MW-1:2], 2'(i)}] <= s_axi_wdata[8*i +: 8];
                end
            end
        end
    end

    // serializer fetch port, one cycle latency
    always_ff @(posedge CMD_CLK_IN) begin
        mem_rd_data <= mem[mem_rd_addr];
    end

    always_comb begin
        rd_value = '0;
        if (rd_is_mem) begin
            for (int i = 0; i < 4; i++) begin
                rd_value[8*i +: 8] = mem[{s_axi_araddr[MW-1:2], 2'(i)}];
            end
        end else begin
            case (s_axi_araddr)
                `CMD_SEQ_REG_START:     rd_value = {31'b0, ready};
                `CMD_SEQ_REG_CONF:      rd_value = {30'b0, cfg.dis_cmd_pulse, cfg.en_ext_start};
                `CMD_SEQ_REG_SIZE:      rd_value = {16'b0, cfg.size};
                `CMD_SEQ_REG_REPEAT:    rd_value = cfg.repeat_cnt;
                `CMD_SEQ_REG_START_REP: rd_value = {16'b0, cfg.start_rep};
                `CMD_SEQ_REG_STOP_REP:  rd_value = {16'b0, cfg.stop_rep};
                default:                rd_value = '0;
            endcase
        end
    end

endmodule

// File: cmd_seq_serializer.sv
// bit serializer: byte fetch, MSB-first bit select, data and start-pulse outputs, ready flag
`include "cmd_seq_settings.svh"

module cmd_seq_serializer (
    input  logic                           CMD_CLK_IN,
    input  logic                           RST_CMD_CLK,
    input  cmd_seq_pkg::cmd_seq_bit_t      bit_req,
    input  logic                           dis_cmd_pulse,
    input  logic [7:0]                     mem_rd_data,
    input  logic                           soft_rst,
    output logic [`CMD_SEQ_MEM_ADDR_W-1:0] mem_rd_addr,
    output logic                           cmd_data,
    output logic                           cmd_start_flag,
    output logic                           ready
);

    // request delayed to line up with the fetched byte
    cmd_seq_pkg::cmd_seq_bit_t req_d;
    logic                      out_last;
    logic                      busy;

    assign mem_rd_addr = bit_req.bit_addr[`CMD_SEQ_BIT_ADDR_W-1:3];

    always_ff @(posedge CMD_CLK_IN) begin
        req_d.bit_addr   <= bit_req.bit_addr;
        req_d.body_first <= bit_req.body_first;
        req_d.last       <= bit_req.last;
        if (RST_CMD_CLK || soft_rst) begin
            req_d.valid    <= 1'b0;
            cmd_data       <= 1'b0;
            cmd_start_flag <= 1'b0;
            out_last       <= 1'b0;
            busy           <= 1'b0;
        end else begin
            req_d.valid    <= bit_req.valid;
            // bit 0 of the pattern is the msb of byte 0
            cmd_data       <= req_d.valid && mem_rd_data[3'd7 - req_d.bit_addr[2:0]];
            cmd_start_flag <= req_d.valid && req_d.body_first && !dis_cmd_pulse;
            out_last       <= req_d.valid && req_d.last;
            if (bit_req.valid) begin
                busy <= 1'b1;
            end else if (out_last) begin
                busy <= 1'b0;
            end
        end
    end

    // low from the first request until the final bit has left cmd_data
    assign ready = !(busy || bit_req.valid);

endmodule

// File: cmd_seq_settings.svh
// command memory size, address widths, register offsets and reset defaults
`ifndef CMD_SEQ_SETTINGS_SVH
`define CMD_SEQ_SETTINGS_SVH

// command memory, 256 bytes hold up to 2048 pattern bits
`define CMD_SEQ_MEM_BYTES       256
`define CMD_SEQ_MEM_ADDR_W      8
`define CMD_SEQ_BIT_ADDR_W      11

// axi4-lite byte address width
`define CMD_SEQ_AXI_ADDR_W      12

// register map
`define CMD_SEQ_REG_RESET       12'h000
`define CMD_SEQ_REG_START       12'h004
`define CMD_SEQ_REG_CONF        12'h008
`define CMD_SEQ_REG_SIZE        12'h00C
`define CMD_SEQ_REG_REPEAT      12'h010
`define CMD_SEQ_REG_START_REP   12'h014
`define CMD_SEQ_REG_STOP_REP    12'h018
`define CMD_SEQ_MEM_BASE        12'h400

// repeat once unless told otherwise
`define CMD_SEQ_REPEAT_DEFAULT  32'd1

`endif

// File: cmd_seq_top.sv
// top level of the command sequencer: register file, engine and serializer
`include "cmd_seq_settings.svh"

module cmd_seq_top (
    input  logic                           CMD_CLK_IN,
    input  logic                           RST_CMD_CLK,
    input  logic [`CMD_SEQ_AXI_ADDR_W-1:0] s_axi_awaddr,
    input  logic                           s_axi_awvalid,
    output logic                           s_axi_awready,
    input  logic [31:0]                    s_axi_wdata,
    input  logic [3:0]                     s_axi_wstrb,
    input  logic                           s_axi_wvalid,
    output logic                           s_axi_wready,
    output logic [1:0]                     s_axi_bresp,
    output logic                           s_axi_bvalid,
    input  logic                           s_axi_bready,
    input  logic [`CMD_SEQ_AXI_ADDR_W-1:0] s_axi_araddr,
    input  logic                           s_axi_arvalid,
    output logic                           s_axi_arready,
    output logic [31:0]                    s_axi_rdata,
    output logic [1:0]                     s_axi_rresp,
    output logic                           s_axi_rvalid,
    input  logic                           s_axi_rready,
    input  logic                           cmd_ext_start,
    output logic                           cmd_ext_start_enable,
    output logic                           cmd_data,
    output logic                           cmd_ready,
    output logic                           cmd_start_flag
);

    cmd_seq_pkg::cmd_seq_cfg_t      cfg;
    cmd_seq_pkg::cmd_seq_bit_t      bit_req;
    logic                           start;
    logic                           soft_rst;
    logic [`CMD_SEQ_MEM_ADDR_W-1:0] mem_rd_addr;
    logic [7:0]                     mem_rd_data;

    // decode
    cmd_seq_regs u_regs (
        .ready (cmd_ready),
        .*
    );

    // execute
    cmd_seq_engine u_engine (
        .ext_start        (cmd_ext_start),
        .ext_start_enable (cmd_ext_start_enable),
        .ready            (cmd_ready),
        .*
    );

    // result
    cmd_seq_serializer u_serializer (
        .dis_cmd_pulse (cfg.dis_cmd_pulse),
        .ready         (cmd_ready),
        .*
    );

endmodule

// File: tb_cmd_seq.sv
// directed testbench of the command sequencer with AXI tasks, stream capture and tests
`include "cmd_seq_settings.svh"

module tb_cmd_seq;
    timeunit 1ns;
    timeprecision 100ps;

    logic CMD_CLK_IN = 1'b0;
    logic RST_CMD_CLK = 1'b1;
    logic [11:0] s_axi_awaddr = '0;
    logic [11:0] s_axi_araddr = '0;
    logic s_axi_awvalid = 1'b0;
    logic s_axi_wvalid = 1'b0;
    logic s_axi_arvalid = 1'b0;
    logic [31:0] s_axi_wdata = '0;
    logic [3:0] s_axi_wstrb = 4'hF;
    logic s_axi_bready = 1'b1;
    logic s_axi_rready = 1'b1;
    logic cmd_ext_start = 1'b0;
    logic s_axi_awready;
    logic s_axi_wready;
    logic s_axi_bvalid;
    logic s_axi_arready;
    logic s_axi_rvalid;
    logic [1:0] s_axi_bresp;
    logic [1:0] s_axi_rresp;
    logic [31:0] s_axi_rdata;
    logic cmd_ext_start_enable;
    logic cmd_data;
    logic cmd_ready;
    logic cmd_start_flag;

    bit [7:0] mem_model [`CMD_SEQ_MEM_BYTES];
    bit exp_bits[$];
    bit exp_flags[$];
    bit got_bits[$];
    bit got_flags[$];
    int errors = 0;
    int checks = 0;
    int seed = 32'ha7266079;
    logic [31:0] rd;

    cmd_seq_top DUT (.*);

    always #4 CMD_CLK_IN = ~CMD_CLK_IN;

    task automatic report_timeout(input string what);
        $display("timeout at %0t ns: %s", $time, what);
        errors++;
    endtask

    task automatic check_value(input string what, input logic [31:0] got, input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            $display("Error at %0t ns: %s is 0x%08h, expected 0x%08h", $time, what, got, exp);
            errors++;
        end
    endtask

    task automatic write_reg(input logic [11:0] addr, input logic [31:0] data);
        int n;
        @(posedge CMD_CLK_IN);
        s_axi_awaddr <= addr;
        s_axi_wdata <= data;
        s_axi_awvalid <= 1'b1;
        s_axi_wvalid <= 1'b1;
        n = 0;
        do begin
            @(negedge CMD_CLK_IN);
            n++;
        end while (!s_axi_awready && n < 50);
        if (!s_axi_awready) begin
            report_timeout("write address was never accepted");
        end else begin
            check_value("wready", s_axi_wready, 32'd1);
        end
        @(posedge CMD_CLK_IN);
        s_axi_awvalid <= 1'b0;
        s_axi_wvalid <= 1'b0;
        n = 0;
        do begin
            @(negedge CMD_CLK_IN);
            n++;
        end while (!s_axi_bvalid && n < 50);
        if (!s_axi_bvalid) begin
            report_timeout("no write response");
        end else begin
            check_value("bresp", s_axi_bresp, 32'd0);
        end
    endtask

    task automatic read_reg(input logic [11:0] addr, output logic [31:0] data);
        int n;
        @(posedge CMD_CLK_IN);
        s_axi_araddr <= addr;
        s_axi_arvalid <= 1'b1;
        n = 0;
        do begin
            @(negedge CMD_CLK_IN);
            n++;
        end while (!s_axi_arready && n < 50);
        if (!s_axi_arready) report_timeout("read address was never accepted");
        @(posedge CMD_CLK_IN);
        s_axi_arvalid <= 1'b0;
        n = 0;
        do begin
            @(negedge CMD_CLK_IN);
            n++;
        end while (!s_axi_rvalid && n < 50);
        if (!s_axi_rvalid) begin
            report_timeout("no read data");
        end else begin
            check_value("rresp", s_axi_rresp, 32'd0);
        end
        data = s_axi_rdata;
    endtask

    // expected stream of header, repeated body and trailer with msb first in each byte
    task automatic build_expected(input int size, input int h, input int t, input int rep,
                                  input bit dis);
        exp_bits.delete();
        exp_flags.delete();
        if (rep == 0) rep = 1;
        for (int k = 0; k < h; k++) begin
            exp_bits.push_back(mem_model[k / 8][7 - k % 8]);
            exp_flags.push_back(1'b0);
        end
        for (int r = 0; r < rep; r++) begin
            for (int k = h; k < size - t; k++) begin
                exp_bits.push_back(mem_model[k / 8][7 - k % 8]);
                exp_flags.push_back(k == h && !dis);
            end
        end
        for (int k = size - t; k < size; k++) begin
            exp_bits.push_back(mem_model[k / 8][7 - k % 8]);
            exp_flags.push_back(1'b0);
        end
    endtask

    // header bit 0 is the third sample taken while busy
    task automatic capture_stream();
        int n;
        got_bits.delete();
        got_flags.delete();
        n = 0;
        do begin
            @(negedge CMD_CLK_IN);
            n++;
        end while (cmd_ready && n < 100);
        if (cmd_ready) begin
            report_timeout("sequencer never went busy");
            return;
        end
        n = 0;
        while (!cmd_ready && n < 20000) begin
            got_bits.push_back(cmd_data);
            got_flags.push_back(cmd_start_flag);
            @(negedge CMD_CLK_IN);
            n++;
        end
        if (!cmd_ready) report_timeout("cmd_ready never returned high");
        if (got_bits.size() >= 2) begin
            void'(got_bits.pop_front());
            void'(got_bits.pop_front());
            void'(got_flags.pop_front());
            void'(got_flags.pop_front());
        end
    endtask

    task automatic compare_stream(input string name);
        checks++;
        if (got_bits.size() != exp_bits.size()) begin
            $display("Error at %0t ns: %s stream has %0d bits, expected %0d", $time, name,
                     got_bits.size(), exp_bits.size());
            errors++;
            return;
        end
        foreach (exp_bits[i]) begin
            if (got_bits[i] !== exp_bits[i] || got_flags[i] !== exp_flags[i]) begin
                $display("Error at %0t ns: %s bit %0d is %b/%b, expected %b/%b", $time, name, i,
                         got_bits[i], got_flags[i], exp_bits[i], exp_flags[i]);
                errors++;
            end
        end
    endtask

    task automatic configure(input int size, input int h, input int t, input int rep,
                             input logic [1:0] conf);
        write_reg(`CMD_SEQ_REG_SIZE, size);
        write_reg(`CMD_SEQ_REG_START_REP, h);
        write_reg(`CMD_SEQ_REG_STOP_REP, t);
        write_reg(`CMD_SEQ_REG_REPEAT, rep);
        write_reg(`CMD_SEQ_REG_CONF, {30'b0, conf});
    endtask

    task automatic run_seq(input int size, input int h, input int t, input int rep, input bit dis);
        configure(size, h, t, rep, {dis, 1'b0});
        build_expected(size, h, t, rep, dis);
        fork
            write_reg(`CMD_SEQ_REG_START, 32'd0);
            capture_stream();
        join
        compare_stream($sformatf("rep %0d dis %0d", rep, dis));
    endtask

    task automatic register_access();
        read_reg(`CMD_SEQ_REG_REPEAT, rd);
        check_value("default repeat", rd, 32'd1);
        read_reg(`CMD_SEQ_REG_SIZE, rd);
        check_value("default size", rd, 32'd0);
        read_reg(`CMD_SEQ_REG_START_REP, rd);
        check_value("default header length", rd, 32'd0);
        read_reg(`CMD_SEQ_REG_STOP_REP, rd);
        check_value("default trailer length", rd, 32'd0);
        read_reg(`CMD_SEQ_REG_CONF, rd);
        check_value("default conf", rd, 32'd0);
        read_reg(`CMD_SEQ_REG_START, rd);
        check_value("ready", rd, 32'd1);
        configure(16'h1234, 16'h0abc, 16'h0def, 32'hdeadbeef, 2'b10);
        read_reg(`CMD_SEQ_REG_SIZE, rd);
        check_value("size", rd, 32'h1234);
        read_reg(`CMD_SEQ_REG_START_REP, rd);
        check_value("header length", rd, 32'h0abc);
        read_reg(`CMD_SEQ_REG_STOP_REP, rd);
        check_value("trailer length", rd, 32'h0def);
        read_reg(`CMD_SEQ_REG_REPEAT, rd);
        check_value("repeat", rd, 32'hdeadbeef);
        read_reg(`CMD_SEQ_REG_CONF, rd);
        check_value("conf", rd, 32'h2);
        for (int w = 0; w < `CMD_SEQ_MEM_BYTES / 4; w++) begin
            rd = $random(seed);
            for (int b = 0; b < 4; b++) mem_model[4 * w + b] = rd[8 * b +: 8];
            write_reg(`CMD_SEQ_MEM_BASE + 12'(4 * w), rd);
        end
        for (int w = 0; w < 8; w++) begin
            read_reg(`CMD_SEQ_MEM_BASE + 12'(4 * w), rd);
            check_value("memory word", rd, {mem_model[4 * w + 3], mem_model[4 * w + 2],
                                            mem_model[4 * w + 1], mem_model[4 * w]});
        end
        read_reg(12'h020, rd);
        check_value("unmapped address", rd, 32'd0);
    endtask

    task automatic external_start();
        configure(64, 8, 8, 1, 2'b00);
        @(posedge CMD_CLK_IN) cmd_ext_start <= 1'b1;
        @(posedge CMD_CLK_IN) cmd_ext_start <= 1'b0;
        repeat (10) @(negedge CMD_CLK_IN);
        check_value("ready after disabled ext start", cmd_ready, 1);
        check_value("ext start enable", cmd_ext_start_enable, 0);
        write_reg(`CMD_SEQ_REG_CONF, 32'h1);
        @(negedge CMD_CLK_IN);
        check_value("ext start enable", cmd_ext_start_enable, 1);
        build_expected(64, 8, 8, 1, 1'b0);
        fork
            capture_stream();
            begin
                @(posedge CMD_CLK_IN) cmd_ext_start <= 1'b1;
                @(posedge CMD_CLK_IN) cmd_ext_start <= 1'b0;
                repeat (10) @(posedge CMD_CLK_IN);
                // second request while busy
                cmd_ext_start <= 1'b1;
                @(posedge CMD_CLK_IN) cmd_ext_start <= 1'b0;
                write_reg(`CMD_SEQ_REG_START, 32'd0);
            end
        join
        compare_stream("external start");
        repeat (10) @(negedge CMD_CLK_IN);
        check_value("ready after single stream", cmd_ready, 1);
    endtask

    task automatic soft_reset_midway();
        int n;
        configure(200, 10, 10, 5, 2'b00);
        write_reg(`CMD_SEQ_REG_START, 32'd0);
        repeat (20) @(posedge CMD_CLK_IN);
        @(negedge CMD_CLK_IN);
        check_value("ready while sending", cmd_ready, 0);
        write_reg(`CMD_SEQ_REG_RESET, 32'd0);
        n = 0;
        while (!cmd_ready && n < 50) begin
            @(negedge CMD_CLK_IN);
            n++;
        end
        if (!cmd_ready) report_timeout("cmd_ready stayed low after soft reset");
        repeat (10) begin
            @(negedge CMD_CLK_IN);
            check_value("cmd_data after soft reset", cmd_data, 0);
        end
        read_reg(`CMD_SEQ_REG_REPEAT, rd);
        check_value("repeat after soft reset", rd, 32'd1);
        read_reg(`CMD_SEQ_REG_SIZE, rd);
        check_value("size after soft reset", rd, 32'd0);
        read_reg(`CMD_SEQ_REG_START_REP, rd);
        check_value("header length after soft reset", rd, 32'd0);
    endtask

    task automatic write_backpressure();
        int n;
        @(posedge CMD_CLK_IN) s_axi_bready <= 1'b0;
        write_reg(`CMD_SEQ_REG_SIZE, 32'h55);
        @(posedge CMD_CLK_IN);
        s_axi_awaddr <= `CMD_SEQ_REG_REPEAT;
        s_axi_wdata <= 32'd7;
        s_axi_awvalid <= 1'b1;
        s_axi_wvalid <= 1'b1;
        repeat (6) begin
            @(negedge CMD_CLK_IN);
            check_value("awready while response pending", s_axi_awready, 0);
            check_value("wready while response pending", s_axi_wready, 0);
            check_value("bvalid held", s_axi_bvalid, 1);
        end
        @(posedge CMD_CLK_IN) s_axi_bready <= 1'b1;
        n = 0;
        do begin
            @(negedge CMD_CLK_IN);
            n++;
        end while (!s_axi_awready && n < 50);
        if (!s_axi_awready) report_timeout("write not accepted after bready rose");
        @(posedge CMD_CLK_IN);
        s_axi_awvalid <= 1'b0;
        s_axi_wvalid <= 1'b0;
        read_reg(`CMD_SEQ_REG_REPEAT, rd);
        check_value("repeat after back-pressure", rd, 32'd7);
        read_reg(`CMD_SEQ_REG_SIZE, rd);
        check_value("size after back-pressure", rd, 32'h55);
    endtask

    initial begin
        repeat (16) @(posedge CMD_CLK_IN);
        RST_CMD_CLK <= 1'b0;
        register_access();
        run_seq(37, 5, 6, 1, 1'b0);
        run_seq(20, 3, 4, 3, 1'b0);
        run_seq(20, 3, 4, 0, 1'b0);
        run_seq(20, 3, 4, 2, 1'b1);
        external_start();
        soft_reset_midway();
        write_backpressure();
        $display("%0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule
